// File: machineCsrTop.f
hdl/csrTypes.sv
hdl/trapTypes.sv
hdl/perfCounterBank.sv
hdl/interruptArbiter.sv
hdl/csrFile.sv
hdl/machineCsrTop.sv
tb/machineCsrTopTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := machineCsrTopTb
FILELIST  := machineCsrTop.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
PASS_TEXT := Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) -o $(TOP)
	@out=$$(./$(BUILD_DIR)/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/machineCsrTopTb.sv
// Self-checking testbench for the machine CSR block.
// Drives CSR requests, traps, MRET, interrupts and perf events on the falling
// edge and checks the responses with assertions against a reference model.

`timescale 1ns/1ps
`default_nettype none

module machineCsrTopTb;
    import csrTypes::*;
    import trapTypes::*;

    localparam int ClkPeriod    = 40;
    localparam int CommitWidth  = 2;
    localparam int ResetCycles  = 8;
    localparam int RmwRounds    = 8;
    localparam int CommitCycles = 24;
    localparam int TrapRounds   = 6;
    localparam int PerfCycles   = 40;
    // Rough cycle budget of all tests, with slack for the short ones
    localparam int TestCycles   = ResetCycles + 9 * RmwRounds + CommitCycles
                                  + 6 * TrapRounds + PerfCycles + 200;

    logic                             clk;
    logic                             rst;
    CsrRequest                        csrReq;
    TrapRequest                       trapReq;
    InterruptRequest                  irqReq;
    logic [$clog2(CommitWidth+1)-1:0] commitNum;
    logic                             timerIrq;
    logic                             externalIrq;
    logic [7:0]                       externalCode;
    logic [3:0]                       perfEvents;
    logic [31:0]                      csrReadData;
    logic [31:0]                      trapTarget;
    logic                             irqPending;
    logic [30:0]                      irqCode;
    logic [7:0]                       externalCodeLatched;
    CsrState                          csrState;

    logic [31:0] rngState = 32'd86699;
    // Reference copies of mscratch, mtvec and mie
    logic [31:0] modelRmw [3];
    logic [31:0] modelMepc;

    machineCsrTop #(
        .CommitWidth(CommitWidth)
    ) machineCsrTop_inst (
        .clk                 (clk),
        .rst                 (rst),
        .csrReq              (csrReq),
        .trapReq             (trapReq),
        .irqReq              (irqReq),
        .commitNum           (commitNum),
        .timerIrq            (timerIrq),
        .externalIrq         (externalIrq),
        .externalCode        (externalCode),
        .perfEvents          (perfEvents),
        .csrReadData         (csrReadData),
        .trapTarget          (trapTarget),
        .irqPending          (irqPending),
        .irqCode             (irqCode),
        .externalCodeLatched (externalCodeLatched),
        .csrState            (csrState)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // Nothing may be offered while interrupts are globally disabled
    assert property (@(posedge clk) disable iff (rst) irqPending |-> csrState.mstatus.MIE)
        else reportFailure("irqPending high while mstatus.MIE is clear");

    task automatic reportFailure(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic checkValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        assert (actual === expected)
            else reportFailure($sformatf("%s is 0x%08h, expected 0x%08h", what, actual, expected));
    endtask

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic logic [31:0] applyOp(CsrOp op, logic [31:0] prior, logic [31:0] data);
        case (op)
            CsrSet:   return prior | data;
            CsrClear: return prior & ~data;
            default:  return data;
        endcase
    endfunction

    // Standard mcause exception codes
    function automatic logic [30:0] expectedCode(TrapCause cause);
        case (cause)
            TrapInsnMisaligned:  return 31'd0;
            TrapInsnViolation:   return 31'd1;
            TrapInsnIllegal:     return 31'd2;
            TrapEbreak:          return 31'd3;
            TrapLoadMisaligned:  return 31'd4;
            TrapLoadViolation:   return 31'd5;
            TrapStoreMisaligned: return 31'd6;
            TrapStoreViolation:  return 31'd7;
            default:             return 31'd11;
        endcase
    endfunction

    function automatic CsrNumber counterNumber(int index);
        return CsrMhpmcounter3 + 12'(index);
    endfunction

    task automatic clearRequests();
        csrReq  = '0;
        trapReq = '0;
        irqReq  = '0;
    endtask

    task automatic presentRead(input CsrNumber number);
        clearRequests();
        csrReq.valid  = 1'b1;
        csrReq.number = number;
        csrReq.op     = CsrWrite;
    endtask

    task automatic readCsr(input CsrNumber number, output logic [31:0] value);
        @(negedge clk);
        presentRead(number);
        #1;
        value = csrReadData;
    endtask

    task automatic writeCsr(input CsrNumber number, input CsrOp op, input logic [31:0] data);
        @(negedge clk);
        presentRead(number);
        csrReq.we        = 1'b1;
        csrReq.op        = op;
        csrReq.writeData = data;
    endtask

    task automatic checkResetState();
        CsrNumber    numbers [8];
        logic [31:0] value;
        numbers = '{CsrMstatus, CsrMie, CsrMip, CsrMcause,
                    CsrMtvec, CsrMtval, CsrMepc, CsrMscratch};
        assert (irqPending === 1'b0) else reportFailure("irqPending high after reset");
        foreach (numbers[i]) begin
            readCsr(numbers[i], value);
            checkValue($sformatf("CSR 0x%03h after reset", numbers[i]), value, 32'd0);
        end
    endtask

    task automatic checkReadModifyWrite();
        CsrNumber    numbers [3];
        CsrOp        op;
        logic [31:0] data;
        logic [31:0] value;
        numbers = '{CsrMscratch, CsrMtvec, CsrMie};
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < RmwRounds; i++) begin
                data = nextRandom();
                // Write, set and clear in turn
                op   = CsrOp'(2'(i % 3) + 2'd1);
                writeCsr(numbers[r], op, data);
                modelRmw[r] = applyOp(op, modelRmw[r], data);
                readCsr(numbers[r], value);
                checkValue($sformatf("CSR 0x%03h after op %0d", numbers[r], op),
                           value, modelRmw[r]);
            end
        end
    endtask

    task automatic checkCounters();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] expected;
        logic [31:0] written;
        logic [1:0]  prev1;
        logic [1:0]  prev2;
        readCsr(CsrMcycle, first);
        readCsr(CsrMcycle, second);
        checkValue("mcycle step", second, first + 32'd1);

        // minstret starts at zero and shows a commit two edges after it is driven
        expected = 32'd0;
        prev1    = '0;
        prev2    = '0;
        for (int i = 0; i < CommitCycles; i++) begin
            @(negedge clk);
            presentRead(CsrMinstret);
            expected += 32'(prev2);
            prev2     = prev1;
            prev1     = (i < CommitCycles - 4) ? 2'(nextRandom() % 3) : 2'd0;
            commitNum = prev1;
            #1;
            checkValue("minstret", csrReadData, expected);
        end

        written = nextRandom();
        writeCsr(CsrMcycle, CsrWrite, written);
        readCsr(CsrMcycle, first);
        checkValue("mcycle after write", first, written);
        readCsr(CsrMcycle, second);
        checkValue("mcycle counting after write", second, written + 32'd1);
    endtask

    task automatic checkTrap();
        TrapCause    cause;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] value;
        logic [3:0]  pick;
        logic        oldMie;
        for (int i = 0; i < TrapRounds; i++) begin
            oldMie = 1'(i % 2);
            writeCsr(CsrMstatus, CsrWrite, {28'd0, oldMie, 3'd0});
            // Any cause but MRET
            pick  = 4'(nextRandom() % 9);
            cause = TrapCause'((pick >= 4'd2) ? pick + 4'd1 : pick);
            pc    = nextRandom();
            addr  = nextRandom();
            @(negedge clk);
            clearRequests();
            trapReq.valid     = 1'b1;
            trapReq.cause     = cause;
            trapReq.causeAddr = pc;
            trapReq.faultAddr = addr;
            #1;
            checkValue("trapTarget", trapTarget, {modelRmw[1][31:2], 2'b00});
            readCsr(CsrMepc, value);
            checkValue("mepc after trap", value, pc);
            checkValue("exported mepc after trap", csrState.mepc, pc);
            readCsr(CsrMtval, value);
            checkValue("mtval after trap", value, addr);
            readCsr(CsrMcause, value);
            checkValue("mcause after trap", value, {1'b0, expectedCode(cause)});
            readCsr(CsrMstatus, value);
            checkValue("mstatus after trap", value, {24'd0, oldMie, 7'd0});
            modelMepc = pc;
        end
    endtask

    task automatic checkMret();
        logic [31:0] value;
        for (int mpie = 1; mpie >= 0; mpie--) begin
            // MIE set to the opposite of MPIE so the restore is visible
            writeCsr(CsrMstatus, CsrWrite, mpie ? 32'h0000_0080 : 32'h0000_0008);
            @(negedge clk);
            clearRequests();
            trapReq.valid = 1'b1;
            trapReq.cause = TrapMret;
            #1;
            checkValue("trapTarget on MRET", trapTarget, modelMepc);
            readCsr(CsrMstatus, value);
            assert (value[3] === 1'(mpie))
                else reportFailure("MRET did not restore mstatus.MIE from MPIE");
        end
    endtask

    task automatic runInterruptCase(input logic [31:0] mieValue, input logic globalEnable,
                                    input logic withExternal);
        logic [31:0] retAddr;
        logic [31:0] value;
        logic [7:0]  code;
        logic        expectPending;
        logic [30:0] expectCode;
        expectPending = globalEnable && (mieValue[7] || (withExternal && mieValue[11]));
        expectCode    = (withExternal && mieValue[11]) ? 31'd11 : 31'd7;
        writeCsr(CsrMie, CsrWrite, mieValue);
        writeCsr(CsrMstatus, CsrWrite, {28'd0, globalEnable, 3'd0});
        code = 8'(nextRandom());
        @(negedge clk);
        clearRequests();
        timerIrq     = 1'b1;
        externalIrq  = withExternal;
        externalCode = code;
        #1;
        assert (irqPending === 1'b0)
            else reportFailure("irqPending rose in the same cycle as the request line");
        @(negedge clk);
        #1;
        assert (irqPending === expectPending)
            else reportFailure($sformatf("irqPending is %0b, expected %0b",
                                         irqPending, expectPending));
        checkValue("externalCodeLatched", 32'(externalCodeLatched), 32'(code));
        if (expectPending) begin
            checkValue("irqCode", 32'(irqCode), 32'(expectCode));
            retAddr = nextRandom();
            @(negedge clk);
            irqReq.valid   = 1'b1;
            irqReq.retAddr = retAddr;
            readCsr(CsrMcause, value);
            checkValue("mcause on interrupt", value, {1'b1, expectCode});
            readCsr(CsrMepc, value);
            checkValue("mepc on interrupt", value, retAddr);
        end
        @(negedge clk);
        clearRequests();
        timerIrq    = 1'b0;
        externalIrq = 1'b0;
    endtask

    task automatic checkPerfCounters();
        logic [31:0] counted [4];
        logic [31:0] value;
        logic [3:0]  bits;
        foreach (counted[i]) begin
            counted[i] = 32'd0;
        end
        for (int n = 0; n < PerfCycles; n++) begin
            @(negedge clk);
            clearRequests();
            bits       = 4'(nextRandom());
            perfEvents = bits;
            foreach (counted[i]) begin
                counted[i] += 32'(bits[i]);
            end
        end
        @(negedge clk);
        perfEvents = '0;
        for (int i = 0; i < 4; i++) begin
            readCsr(counterNumber(i), value);
            checkValue($sformatf("mhpmcounter%0d", i + 3), value, counted[i]);
        end
        // A write clears the counter even with an event in the same cycle
        for (int i = 0; i < 4; i++) begin
            writeCsr(counterNumber(i), CsrWrite, nextRandom());
            perfEvents = 4'(1 << i);
            @(negedge clk);
            perfEvents = '0;
            presentRead(counterNumber(i));
            #1;
            checkValue($sformatf("mhpmcounter%0d after write", i + 3), csrReadData, 32'd0);
        end
    endtask

    initial begin
        #(TestCycles * ClkPeriod);
        $display("Watchdog timeout: the tests did not finish within %0d cycles", TestCycles);
        $display("Test failed");
        $fatal(1, "Simulation stopped by the watchdog");
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        commitNum    = '0;
        timerIrq     = 1'b0;
        externalIrq  = 1'b0;
        externalCode = '0;
        perfEvents   = '0;
        modelMepc    = '0;
        foreach (modelRmw[i]) begin
            modelRmw[i] = '0;
        end
        clearRequests();
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        checkResetState();
        checkReadModifyWrite();
        checkCounters();
        checkTrap();
        checkMret();
        runInterruptCase(32'h0000_0880, 1'b1, 1'b0);
        runInterruptCase(32'h0000_0880, 1'b1, 1'b1);
        runInterruptCase(32'h0000_0080, 1'b1, 1'b1);
        runInterruptCase(32'h0000_0880, 1'b0, 1'b1);
        runInterruptCase(32'h0000_0000, 1'b1, 1'b1);
        checkPerfCounters();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/machineCsrTop.sv
// Top of the machine CSR block.
// Wires the CSR file to the interrupt arbiter and the perf counter bank.

`timescale 1ns/1ps
`default_nettype none

module machineCsrTop #(
    parameter int CommitWidth = 2
) (
    input  logic                               clk,
    input  logic                               rst,
    input  trapTypes::CsrRequest               csrReq,
    input  trapTypes::TrapRequest              trapReq,
    input  trapTypes::InterruptRequest         irqReq,
    input  logic [$clog2(CommitWidth+1)-1:0]   commitNum,
    input  logic                               timerIrq,
    input  logic                               externalIrq,
    input  logic [7:0]                         externalCode,
    input  logic [3:0]                         perfEvents,
    output logic [31:0]                        csrReadData,
    output logic [31:0]                        trapTarget,
    output logic                               irqPending,
    output logic [30:0]                        irqCode,
    output logic [7:0]                         externalCodeLatched,
    output csrTypes::CsrState                  csrState
);

    logic [3:0][31:0] perfValues;
    logic [3:0]       counterClear;

    csrFile #(
        .CommitWidth(CommitWidth)
    ) csrFile_inst (
        .clk          (clk),
        .rst          (rst),
        .csrReq       (csrReq),
        .trapReq      (trapReq),
        .irqReq       (irqReq),
        .irqCode      (irqCode),
        .commitNum    (commitNum),
        .timerIrq     (timerIrq),
        .externalIrq  (externalIrq),
        .perfValues   (perfValues),
        .csrReadData  (csrReadData),
        .trapTarget   (trapTarget),
        .counterClear (counterClear),
        .csrState     (csrState)
    );

    interruptArbiter interruptArbiter_inst (
        .clk                 (clk),
        .rst                 (rst),
        .csrState            (csrState),
        .externalCode        (externalCode),
        .irqPending          (irqPending),
        .irqCode             (irqCode),
        .externalCodeLatched (externalCodeLatched)
    );

    perfCounterBank perfCounterBank_inst (
        .clk          (clk),
        .rst          (rst),
        .events       (perfEvents),
        .counterClear (counterClear),
        .counts       (perfValues)
    );

endmodule

`default_nettype wire

// File: hdl/csrFile.sv
// Machine-mode CSR register file.
// Serves combinational reads, applies writes, traps, MRET and interrupt
// entry at the next edge, and keeps mcycle and minstret running.

`timescale 1ns/1ps
`default_nettype none

module csrFile #(
    parameter int CommitWidth = 1
) (
    input  logic                               clk,
    input  logic                               rst,
    input  trapTypes::CsrRequest               csrReq,
    input  trapTypes::TrapRequest              trapReq,
    input  trapTypes::InterruptRequest         irqReq,
    input  logic [30:0]                        irqCode,
    input  logic [$clog2(CommitWidth+1)-1:0]   commitNum,
    input  logic                               timerIrq,
    input  logic                               externalIrq,
    input  logic [3:0][csrTypes::Xlen-1:0]     perfValues,
    output logic [csrTypes::Xlen-1:0]          csrReadData,
    output logic [csrTypes::Xlen-1:0]          trapTarget,
    output logic [3:0]                         counterClear,
    output csrTypes::CsrState                  csrState
);
    import csrTypes::*;
    import trapTypes::*;

    CsrState                          csrReg;
    CsrState                          csrNext;
    logic [$clog2(CommitWidth+1)-1:0] regCommitNum;
    logic [Xlen-1:0]                  readValue;
    logic [Xlen-1:0]                  writeValue;
    logic                             writeTaken;
    logic                             isMret;

    // Retire count is staged one cycle before it reaches minstret
    always_ff @(posedge clk) begin
        if (rst) begin
            csrReg       <= '0;
            regCommitNum <= '0;
        end else begin
            csrReg       <= csrNext;
            regCommitNum <= commitNum;
        end
    end

    // Interrupt and trap take precedence over a CSR update
    assign writeTaken = csrReq.valid && csrReq.we && !trapReq.valid && !irqReq.valid;
    assign isMret     = (trapReq.cause == TrapMret);

    always_comb begin
        case (csrReq.number)
            CsrMstatus:      readValue = csrReg.mstatus;
            CsrMip:          readValue = csrReg.mip;
            CsrMie:          readValue = csrReg.mie;
            CsrMcause:       readValue = csrReg.mcause;
            CsrMtvec:        readValue = csrReg.mtvec;
            CsrMtval:        readValue = csrReg.mtval;
            CsrMepc:         readValue = csrReg.mepc;
            CsrMscratch:     readValue = csrReg.mscratch;
            CsrMcycle:       readValue = csrReg.mcycle;
            CsrMinstret:     readValue = csrReg.minstret;
            CsrMhpmcounter3: readValue = perfValues[0];
            CsrMhpmcounter4: readValue = perfValues[1];
            CsrMhpmcounter5: readValue = perfValues[2];
            CsrMhpmcounter6: readValue = perfValues[3];
            default:         readValue = '0;
        endcase
    end

    // Read-modify-write value
    always_comb begin
        case (csrReq.op)
            CsrWrite: writeValue = csrReq.writeData;
            CsrSet:   writeValue = readValue | csrReq.writeData;
            CsrClear: writeValue = readValue & ~csrReq.writeData;
            default:  writeValue = csrReq.writeData;
        endcase
    end

    // Any write to a perf counter resets it in the counter bank
    assign counterClear[0] = writeTaken && (csrReq.number == CsrMhpmcounter3);
    assign counterClear[1] = writeTaken && (csrReq.number == CsrMhpmcounter4);
    assign counterClear[2] = writeTaken && (csrReq.number == CsrMhpmcounter5);
    assign counterClear[3] = writeTaken && (csrReq.number == CsrMhpmcounter6);

    always_comb begin
        csrNext          = csrReg;
        csrNext.mcycle   = csrReg.mcycle + 1'b1;
        csrNext.minstret = csrReg.minstret + Xlen'(regCommitNum);

        if (irqReq.valid) begin
            csrNext.mstatus.MPIE    = csrReg.mstatus.MIE;
            csrNext.mstatus.MIE     = 1'b0;
            csrNext.mepc            = irqReq.retAddr;
            csrNext.mtval           = irqReq.retAddr;
            csrNext.mcause.isInterrupt = 1'b1;
            csrNext.mcause.code     = irqCode;
        end else if (trapReq.valid) begin
            if (isMret) begin
                csrNext.mstatus.MIE = csrReg.mstatus.MPIE;
            end else begin
                csrNext.mstatus.MPIE    = csrReg.mstatus.MIE;
                csrNext.mstatus.MIE     = 1'b0;
                csrNext.mepc            = trapReq.causeAddr;
                csrNext.mtval           = trapReq.faultAddr;
                csrNext.mcause.isInterrupt = 1'b0;
                csrNext.mcause.code     = trapCodeOf(trapReq.cause);
            end
        end else if (writeTaken) begin
            // mip is read-only and perf counters are cleared in the counter bank
            case (csrReq.number)
                CsrMstatus:  csrNext.mstatus  = writeValue;
                CsrMie:      csrNext.mie      = writeValue;
                CsrMcause:   csrNext.mcause   = writeValue;
                CsrMtvec:    csrNext.mtvec    = writeValue;
                CsrMtval:    csrNext.mtval    = writeValue;
                CsrMepc:     csrNext.mepc     = writeValue;
                CsrMscratch: csrNext.mscratch = writeValue;
                CsrMcycle:   csrNext.mcycle   = writeValue;
                CsrMinstret: csrNext.minstret = writeValue;
                default:     ;
            endcase
        end

        // Pending bits follow the request lines
        csrNext.mip.MTIP = timerIrq;
        csrNext.mip.MEIP = externalIrq;
    end

    assign csrReadData = readValue;
    assign trapTarget  = isMret ? csrReg.mepc : {csrReg.mtvec.base, 2'b00};
    assign csrState    = csrReg;

endmodule

`default_nettype wire

// File: hdl/interruptArbiter.sv
// Chooses which machine interrupt to offer to the pipeline.
// External beats timer; nothing is offered while mstatus.MIE is clear.
// Also keeps the external interrupt source code, latched one cycle.

`timescale 1ns/1ps
`default_nettype none

module interruptArbiter (
    input  logic                clk,
    input  logic                rst,
    input  csrTypes::CsrState   csrState,
    input  logic [7:0]          externalCode,
    output logic                irqPending,
    output logic [30:0]         irqCode,
    output logic [7:0]          externalCodeLatched
);
    import csrTypes::*;
    import trapTypes::*;

    MInterruptBits enabled;

    // The request is seen in mip a cycle late, so the code is delayed too
    always_ff @(posedge clk) begin
        if (rst) begin
            externalCodeLatched <= '0;
        end else begin
            externalCodeLatched <= externalCode;
        end
    end

    assign enabled = csrState.mip & csrState.mie;

    always_comb begin
        irqPending = csrState.mstatus.MIE && (enabled.MEIP || enabled.MTIP);

        if (enabled.MEIP) begin
            irqCode = IrqMachineExternal;
        end else if (enabled.MTIP) begin
            irqCode = IrqMachineTimer;
        end else begin
            irqCode = '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/perfCounterBank.sv
// Hardware performance counters behind mhpmcounter3 to mhpmcounter6.
// Each counter adds one per cycle its event bit is high.

`timescale 1ns/1ps
`default_nettype none

module perfCounterBank (
    input  logic             clk,
    input  logic             rst,
    input  logic [3:0]       events,
    input  logic [3:0]       counterClear,
    output logic [3:0][31:0] counts
);

    localparam int NumCounters = 4;

    // Lane order: load miss, store miss, icache miss, branch mispredict
    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < NumCounters; i++) begin
                // Clear has priority over a same-cycle event
                if (counterClear[i]) begin
                    counts[i] <= '0;
                end else if (events[i]) begin
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/trapTypes.sv
// Request types the pipeline drives into the CSR block each cycle.
// Also holds trap causes, their mcause codes and the interrupt codes.

`default_nettype none

package trapTypes;

    typedef enum logic [3:0] {
        TrapEcall,
        TrapEbreak,
        TrapMret,
        TrapLoadMisaligned,
        TrapLoadViolation,
        TrapStoreMisaligned,
        TrapStoreViolation,
        TrapInsnIllegal,
        TrapInsnViolation,
        TrapInsnMisaligned
    } TrapCause;

    typedef logic [csrTypes::Xlen-2:0] InterruptCode;

    localparam InterruptCode IrqMachineTimer    = 31'd7;
    localparam InterruptCode IrqMachineExternal = 31'd11;

    typedef struct packed {
        logic                        valid;
        logic                        we;
        csrTypes::CsrNumber          number;
        csrTypes::CsrOp              op;
        logic [csrTypes::Xlen-1:0]   writeData;
    } CsrRequest;

    typedef struct packed {
        logic                        valid;
        TrapCause                    cause;
        logic [csrTypes::Xlen-1:0]   causeAddr;
        logic [csrTypes::Xlen-1:0]   faultAddr;
    } TrapRequest;

    typedef struct packed {
        logic                        valid;
        logic [csrTypes::Xlen-1:0]   retAddr;
    } InterruptRequest;

    // Standard exception codes, ECALL is taken from M-mode
    function automatic logic [csrTypes::Xlen-2:0] trapCodeOf(TrapCause cause);
        case (cause)
            TrapInsnMisaligned:  return 31'd0;
            TrapInsnViolation:   return 31'd1;
            TrapInsnIllegal:     return 31'd2;
            TrapEbreak:          return 31'd3;
            TrapLoadMisaligned:  return 31'd4;
            TrapLoadViolation:   return 31'd5;
            TrapStoreMisaligned: return 31'd6;
            TrapStoreViolation:  return 31'd7;
            TrapEcall:           return 31'd11;
            default:             return 31'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hdl/csrTypes.sv
// Types for the machine-mode CSR state of the RV32 core.
// Holds the CSR numbers, register layouts and read-modify-write codes.
// Modules import it inside their body and use scoped names in port lists.

`default_nettype none

package csrTypes;

    localparam int Xlen = 32;

    // 12-bit CSR address space
    typedef logic [11:0] CsrNumber;

    localparam CsrNumber CsrMstatus      = 12'h300;
    localparam CsrNumber CsrMie          = 12'h304;
    localparam CsrNumber CsrMtvec        = 12'h305;
    localparam CsrNumber CsrMscratch     = 12'h340;
    localparam CsrNumber CsrMepc         = 12'h341;
    localparam CsrNumber CsrMcause       = 12'h342;
    localparam CsrNumber CsrMtval        = 12'h343;
    localparam CsrNumber CsrMip          = 12'h344;
    localparam CsrNumber CsrMcycle       = 12'hB00;
    localparam CsrNumber CsrMinstret     = 12'hB02;
    localparam CsrNumber CsrMhpmcounter3 = 12'hB03;
    localparam CsrNumber CsrMhpmcounter4 = 12'hB04;
    localparam CsrNumber CsrMhpmcounter5 = 12'hB05;
    localparam CsrNumber CsrMhpmcounter6 = 12'hB06;

    // Matches funct3[1:0] of CSRRW, CSRRS and CSRRC
    typedef enum logic [1:0] {
        CsrWrite = 2'd1,
        CsrSet   = 2'd2,
        CsrClear = 2'd3
    } CsrOp;

    // Only MIE and MPIE have meaning here
    typedef struct packed {
        logic [23:0] upperBits;
        logic        MPIE;
        logic [2:0]  middleBits;
        logic        MIE;
        logic [2:0]  lowerBits;
    } MStatus;

    // Shared layout of mip and mie
    typedef struct packed {
        logic [19:0] upperBits;
        logic        MEIP;
        logic [2:0]  middleBits;
        logic        MTIP;
        logic [6:0]  lowerBits;
    } MInterruptBits;

    // Direct mode only, the mode field is kept as written
    typedef struct packed {
        logic [Xlen-3:0] base;
        logic [1:0]      mode;
    } MTvec;

    typedef struct packed {
        logic            isInterrupt;
        logic [Xlen-2:0] code;
    } MCause;

    typedef struct packed {
        MStatus          mstatus;
        MInterruptBits   mip;
        MInterruptBits   mie;
        MCause           mcause;
        MTvec            mtvec;
        logic [Xlen-1:0] mtval;
        logic [Xlen-1:0] mepc;
        logic [Xlen-1:0] mscratch;
        logic [Xlen-1:0] mcycle;
        logic [Xlen-1:0] minstret;
    } CsrState;

endpackage

`default_nettype wire
